// File: hdl/csr_pkg.sv
package csr_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XLEN       = 32;  // data path width.
    localparam int CSR_ADDR_W = 12;  // csr address space as in the isa.
    localparam int REG_ADDR_W = 5;   // destination register index.

    // opcodes of the csr instructions. codes 4 to 7 are illegal.
    typedef enum logic [2:0] {
        CSR_NOP = 3'd0,
        CSR_RW  = 3'd1,
        CSR_RS  = 3'd2,
        CSR_RC  = 3'd3
    } csr_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // machine csr addresses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [CSR_ADDR_W-1:0] CSR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID  = 12'hF14;

    // only msie, mtie and meie can be written in mie.
    localparam logic [XLEN-1:0] MIE_WMASK = 32'h0000_0888;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command and result records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        csr_op_e                op;       // instruction kind.
        logic [CSR_ADDR_W-1:0]  addr;     // target csr.
        logic [XLEN-1:0]        operand;  // rs1 value.
        logic [REG_ADDR_W-1:0]  rd;       // where the old value goes.
    } csr_cmd_t;

    typedef struct packed {
        logic [XLEN-1:0]        data;  // old csr value, zero on error.
        logic [REG_ADDR_W-1:0]  rd;
        logic                   err;
    } csr_result_t;

    typedef struct packed {
        logic [CSR_ADDR_W-1:0]  addr;
    } csr_rd_req_t;

    typedef struct packed {
        logic                   we;
        logic [CSR_ADDR_W-1:0]  addr;
        logic [XLEN-1:0]        data;
    } csr_wr_req_t;

endpackage

// File: hdl/csr_exec_unit.sv
`timescale 1ns/10ps

module csr_exec_unit import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  csr_cmd_t        i_cmd,
    input  logic            i_clear,
    input  logic [XLEN-1:0] i_rdata,
    input  logic            i_err,
    output csr_rd_req_t     o_rd_req,
    output csr_wr_req_t     o_wr_req,
    output logic            o_busy,
    output logic            o_illegal,
    output logic            o_valid,
    output csr_result_t     o_result
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_HOLD
    } state_e;

    state_e state;
    state_e state_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // latched command
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    csr_op_e                op_q;
    logic [CSR_ADDR_W-1:0]  addr_q;
    logic [XLEN-1:0]        operand_q;  // already inverted for CSR_RC.
    logic [REG_ADDR_W-1:0]  rd_q;

    // old value and error flag, captured in READ.
    logic [XLEN-1:0]        old_q;
    logic                   err_q;

    logic                   op_legal;
    logic                   accept;
    logic [XLEN-1:0]        wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (i_cmd.op)
            CSR_NOP, CSR_RW, CSR_RS, CSR_RC: op_legal = 1'b1;
            default:                         op_legal = 1'b0;
        endcase
    end

    // a nop is legal but starts nothing.
    assign accept    = (state == S_IDLE) && op_legal && (i_cmd.op != CSR_NOP);
    assign o_illegal = (state == S_IDLE) && !op_legal;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_nxt = S_READ;
                end
            end
            S_READ:  state_nxt = S_WRITE;
            S_WRITE: state_nxt = i_clear ? S_IDLE : S_HOLD;  // clear may come right away.
            S_HOLD: begin
                if (i_clear) begin
                    state_nxt = S_IDLE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // command fields are taken once, when the command is accepted.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= i_cmd.op;
            addr_q    <= i_cmd.addr;
            rd_q      <= i_cmd.rd;
            operand_q <= (i_cmd.op == CSR_RC) ? ~i_cmd.operand : i_cmd.operand;
        end
        if (state == S_READ) begin
            old_q <= i_err ? '0 : i_rdata;  // a failed access reports zero.
            err_q <= i_err;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // modify
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (op_q)
            CSR_RS:  wdata = old_q | operand_q;
            CSR_RC:  wdata = old_q & operand_q;  // operand_q holds ~rs1 here.
            default: wdata = operand_q;
        endcase
    end

    assign o_rd_req = '{addr: addr_q};

    // the csr file drops the write itself when the address is in error.
    assign o_wr_req = '{
        we:   (state == S_WRITE),
        addr: addr_q,
        data: wdata
    };

    assign o_busy   = (state != S_IDLE);
    assign o_valid  = (state == S_WRITE) || (state == S_HOLD);
    assign o_result = '{data: old_q, rd: rd_q, err: err_q};

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/10ps

module csr_file import csr_pkg::*; #(
    parameter logic [XLEN-1:0] HART_ID    = '0,
    parameter logic [XLEN-1:0] MISA_VALUE = 32'h4000_1100
) (
    input  logic            clk,
    input  logic            rst_n,
    input  csr_rd_req_t     i_rd_req,
    input  csr_wr_req_t     i_wr_req,
    output logic [XLEN-1:0] o_rdata,
    output logic            o_err
);

    // mtvec is kept word aligned, mepc halfword aligned.
    localparam logic [XLEN-1:0] MTVEC_WMASK = {{(XLEN-2){1'b1}}, 2'b00};
    localparam logic [XLEN-1:0] MEPC_WMASK  = {{(XLEN-1){1'b1}}, 1'b0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mie;

    logic            rd_mapped;
    logic            rd_read_only;
    logic            wr_ok;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic is_mapped(input logic [CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_MSCRATCH,
            CSR_MTVEC,
            CSR_MEPC,
            CSR_MCAUSE,
            CSR_MIE,
            CSR_MISA,
            CSR_MHARTID: return 1'b1;
            default:     return 1'b0;
        endcase
    endfunction

    // the top two address bits mark the read-only range. misa sits below
    // that range, so it is named on its own.
    function automatic logic is_read_only(input logic [CSR_ADDR_W-1:0] addr);
        return (addr[CSR_ADDR_W-1 -: 2] == 2'b11) || (addr == CSR_MISA);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rd_mapped    = is_mapped(i_rd_req.addr);
    assign rd_read_only = is_read_only(i_rd_req.addr);

    // every instruction writes back, so a read-only target is already an error at read time.
    assign o_err = !rd_mapped || rd_read_only;

    always_comb begin
        case (i_rd_req.addr)
            CSR_MSCRATCH: o_rdata = mscratch;
            CSR_MTVEC:    o_rdata = mtvec;
            CSR_MEPC:     o_rdata = mepc;
            CSR_MCAUSE:   o_rdata = mcause;
            CSR_MIE:      o_rdata = mie;
            CSR_MISA:     o_rdata = MISA_VALUE;
            CSR_MHARTID:  o_rdata = HART_ID;
            default:      o_rdata = '0;  // unmapped reads as zero.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the write address is checked again, so a bad access never lands.
    assign wr_ok = i_wr_req.we
                && is_mapped(i_wr_req.addr)
                && !is_read_only(i_wr_req.addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mie      <= '0;
        end else if (wr_ok) begin
            case (i_wr_req.addr)
                CSR_MSCRATCH: mscratch <= i_wr_req.data;
                CSR_MTVEC:    mtvec    <= i_wr_req.data & MTVEC_WMASK;
                CSR_MEPC:     mepc     <= i_wr_req.data & MEPC_WMASK;
                CSR_MCAUSE:   mcause   <= i_wr_req.data;
                CSR_MIE:      mie      <= i_wr_req.data & MIE_WMASK;
                default: begin
                    // read-only and unmapped addresses never get here.
                end
            endcase
        end
    end

endmodule

// File: hdl/csr_unit_top.sv
`timescale 1ns/10ps

module csr_unit_top import csr_pkg::*; #(
    parameter logic [XLEN-1:0] HART_ID    = '0,
    parameter logic [XLEN-1:0] MISA_VALUE = 32'h4000_1100
) (
    input  logic        clk,
    input  logic        rst_n,
    input  csr_cmd_t    i_cmd,
    input  logic        i_clear,
    output logic        o_busy,
    output logic        o_illegal,
    output logic        o_valid,
    output csr_result_t o_result
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exec unit to csr file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    csr_rd_req_t     rd_req;
    csr_wr_req_t     wr_req;
    logic [XLEN-1:0] csr_rdata;  // answered in the same cycle.
    logic            csr_err;

    csr_exec_unit u_exec_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd     (i_cmd),
        .i_clear   (i_clear),
        .i_rdata   (csr_rdata),
        .i_err     (csr_err),
        .o_rd_req  (rd_req),
        .o_wr_req  (wr_req),
        .o_busy    (o_busy),
        .o_illegal (o_illegal),
        .o_valid   (o_valid),
        .o_result  (o_result)
    );

    csr_file #(
        .HART_ID    (HART_ID),
        .MISA_VALUE (MISA_VALUE)
    ) u_csr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_rd_req (rd_req),
        .i_wr_req (wr_req),
        .o_rdata  (csr_rdata),
        .o_err    (csr_err)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5  // 10 ns period.
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) o_clk = ~o_clk;

endmodule

// File: testbench/csr_unit_chk.sv
`timescale 1ns/10ps

module csr_unit_chk import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_busy,
    input  logic        i_valid,
    input  logic        i_clear,
    input  csr_result_t i_result,
    input  csr_wr_req_t i_wr_req
);

    // number of assertion failures.
    int unsigned fail_count = 0;

    // a result is only ever shown while the unit is busy.
    valid_implies_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_valid |-> i_busy)
    else begin
        fail_count++;
        $error("o_valid is high while o_busy is low");
    end

    write_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        i_wr_req.we |=> !i_wr_req.we)
    else begin
        fail_count++;
        $error("write enable stayed high for more than one cycle");
    end

    // the held result must not move until the clear edge.
    result_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (i_valid && !i_clear) |=> $stable(i_result))
    else begin
        fail_count++;
        $error("o_result changed while held");
    end

endmodule

// File: testbench/csr_unit_tb.sv
`timescale 1ns/10ps

module csr_unit_tb import csr_pkg::*; ();

    localparam int RESET_CYCLES  = 10;
    localparam int CYCLES_PER_VEC = 40;
    localparam int VALID_WAIT    = 8;  // edge 2 plus some slack.

    typedef struct packed {
        csr_cmd_t    cmd;
        csr_result_t exp;
        logic        exp_ill;
        logic [7:0]  clear_delay;  // cycles to hold before clear.
    } vec_t;

    logic        clk;
    logic        rst_n;
    csr_cmd_t    i_cmd;
    logic        i_clear;
    logic        o_busy;
    logic        o_illegal;
    logic        o_valid;
    csr_result_t o_result;

    vec_t        vec_q[$];
    logic        loaded = 1'b0;
    int unsigned error_count = 0;
    int unsigned check_count = 0;

    tb_clock_gen u_clock_gen (.o_clk(clk));

    csr_unit_top #(
        .HART_ID    (32'd3),
        .MISA_VALUE (32'h4000_1100)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd     (i_cmd),
        .i_clear   (i_clear),
        .o_busy    (o_busy),
        .o_illegal (o_illegal),
        .o_valid   (o_valid),
        .o_result  (o_result)
    );

    bind csr_exec_unit csr_unit_chk u_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_busy   (o_busy),
        .i_valid  (o_valid),
        .i_clear  (i_clear),
        .i_result (o_result),
        .i_wr_req (o_wr_req)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare_result(input csr_result_t got, input csr_result_t exp,
                                  input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL @%0t: %s data %h rd %0d err %b, expected data %h rd %0d err %b",
                     $time, what, got.data, got.rd, got.err, exp.data, exp.rd, exp.err);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vectors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_vectors();
        integer      fd;
        integer      n;
        string       line;
        logic [31:0] f_op, f_addr, f_opnd, f_rd, f_data, f_err, f_ill, f_dly;
        vec_t        v;
        fd = $fopen("testbench/csr_unit_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/csr_unit_input.txt for reading");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f_op, f_addr, f_opnd, f_rd, f_data, f_err, f_ill, f_dly);
            if (n == 8) begin  // comment and blank lines give fewer fields.
                v.cmd.op      = csr_op_e'(f_op[2:0]);
                v.cmd.addr    = f_addr[CSR_ADDR_W-1:0];
                v.cmd.operand = f_opnd;
                v.cmd.rd      = f_rd[REG_ADDR_W-1:0];
                v.exp.data    = f_data;
                v.exp.rd      = f_rd[REG_ADDR_W-1:0];
                v.exp.err     = f_err[0];
                v.exp_ill     = f_ill[0];
                v.clear_delay = f_dly[7:0];
                vec_q.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int idx);
        vec_t        v;
        int          waited;
        int unsigned errors_before;
        v = vec_q[idx];
        errors_before = error_count;
        @(posedge clk);
        i_cmd <= v.cmd;
        @(negedge clk);
        compare_flag("o_illegal", o_illegal, v.exp_ill);
        if (v.exp_ill) begin
            @(posedge clk);
            i_cmd <= '0;
            @(negedge clk);
            compare_flag("o_busy after illegal op", o_busy, 1'b0);
        end else begin
            @(posedge clk);  // edge 0, the command is taken here.
            i_cmd <= '0;
            waited = 0;
            @(negedge clk);
            while (!o_valid && waited < VALID_WAIT) begin
                @(negedge clk);
                waited++;
            end
            if (!o_valid) begin
                error_count++;
                $display("vector %0d: no valid result within %0d cycles", idx, VALID_WAIT);
            end else begin
                compare_flag("o_busy with result", o_busy, 1'b1);
                compare_result(o_result, v.exp, "result");
                repeat (v.clear_delay) begin
                    @(negedge clk);
                    compare_flag("o_valid while held", o_valid, 1'b1);
                    compare_result(o_result, v.exp, "held result");
                end
            end
            @(posedge clk);
            i_clear <= 1'b1;
            @(posedge clk);
            i_clear <= 1'b0;
            @(negedge clk);
            compare_flag("o_busy after clear", o_busy, 1'b0);
            compare_flag("o_valid after clear", o_valid, 1'b0);
        end
        $display("vector %0d op %0d addr %h: %s", idx, v.cmd.op, v.cmd.addr,
                 (error_count == errors_before) ? "pass" : "fail");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n   = 1'b0;
        i_cmd   = '0;
        i_clear = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < vec_q.size(); i++) begin
            run_vector(i);
        end
        if (vec_q.size() == 0) begin
            error_count++;
            $display("no vectors were read, nothing was tested");
        end
        if (i_dut.u_exec_unit.u_chk.fail_count != 0) begin
            $display("handshake assertions failed %0d times",
                     i_dut.u_exec_unit.u_chk.fail_count);
            error_count += i_dut.u_exec_unit.u_chk.fail_count;
        end
        $display("vectors %0d, checks %0d, errors %0d", vec_q.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + (vec_q.size() + 1) * CYCLES_PER_VEC) @(posedge clk);
        $display("timeout: the vectors did not finish in the allowed cycles");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: testbench/csr_unit_input.txt
# columns, all hex: op addr operand rd exp_data exp_err exp_illegal clear_delay
# op 1 = rw, 2 = rs, 3 = rc, 4..7 illegal. hart id 3, misa 40001100.
1 340 DEADBEEF 01 00000000 0 0 0
1 340 12345678 02 DEADBEEF 0 0 0
1 340 00000000 03 12345678 0 0 0
1 342 0000000F 04 00000000 0 0 0
2 342 80000030 05 0000000F 0 0 0
3 342 00000005 06 8000003F 0 0 0
2 342 00000000 07 8000003A 0 0 0
3 342 FFFFFFFF 08 8000003A 0 0 0
2 342 00000000 09 00000000 0 0 0
1 305 FFFFFFFF 0A 00000000 0 0 0
1 305 00001003 0B FFFFFFFC 0 0 0
2 305 00000000 0C 00001000 0 0 0
1 341 80000003 0D 00000000 0 0 0
3 341 00000000 0E 80000002 0 0 0
1 304 FFFFFFFF 0F 00000000 0 0 0
3 304 00000080 10 00000888 0 0 0
2 304 00000000 11 00000808 0 0 0
2 301 00000000 12 00000000 1 0 0
1 301 00000000 13 00000000 1 0 0
3 F14 FFFFFFFF 14 00000000 1 0 0
1 7C0 12345678 15 00000000 1 0 0
1 340 AAAA5555 16 00000000 0 0 0
4 340 FFFFFFFF 17 00000000 0 1 0
7 342 FFFFFFFF 17 00000000 0 1 0
1 340 00000000 18 AAAA5555 0 0 0
2 342 00000100 19 00000000 0 0 6
1 342 00000000 1A 00000100 0 0 0
1 305 00000040 1B 00001000 0 0 9
2 305 00000000 1C 00000040 0 0 0

// File: csr_unit_top.f
hdl/csr_pkg.sv
hdl/csr_exec_unit.sv
hdl/csr_file.sv
hdl/csr_unit_top.sv
testbench/tb_clock_gen.sv
testbench/csr_unit_chk.sv
testbench/csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  # design sources in compile order
  - files:
      - hdl/csr_pkg.sv
      - hdl/csr_exec_unit.sv
      - hdl/csr_file.sv
      - hdl/csr_unit_top.sv

  # simulation only
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/csr_unit_chk.sv
      - testbench/csr_unit_tb.sv
